// File: hw/memPipe_consts.svh
`ifndef MEMPIPE_CONSTS_SVH
`define MEMPIPE_CONSTS_SVH

// data word width, also used for the pc
`define DATA_WIDTH 32

// register number width, 32 registers
`define REG_ADDR_WIDTH 5

// words held by the data memory
`define MEM_DEPTH 256

// word index width into the data memory
// must match MEM_DEPTH
`define MEM_ADDR_WIDTH 8

// bits of a byte address below the word index
`define BYTE_SEL_WIDTH 2

`endif

// File: hw/memPipe_pkg.sv
package memPipe_pkg;

    // operation carried by one pipeline record
    // bubble first so a cleared register decodes as opNone
    typedef enum logic [2:0] {
        // empty slot
        opNone      = 3'd0,
        // alu result to register
        opAluWrite  = 3'd1,
        // whole word from memory to register
        opLoadWord  = 3'd2,
        // one byte from memory, sign-extended
        opLoadByte  = 3'd3,
        // whole word to memory
        opStoreWord = 3'd4,
        // low byte to one memory lane
        opStoreByte = 3'd5
    } memOp;

endpackage

// File: hw/dataMemory.sv
`timescale 1ns/1ps
`include "memPipe_consts.svh"

module dataMemory
    import memPipe_pkg::*;
(
    input  logic                       clk,
    input  logic [`MEM_ADDR_WIDTH-1:0] wordAddr,
    input  logic [`BYTE_SEL_WIDTH-1:0] byteSel,
    input  memOp                       op,
    input  logic                       writeEn,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    output logic [`DATA_WIDTH-1:0]     readData
);

    // word array, byte lanes addressed inside each word
    logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

    // word at the current index
    logic [`DATA_WIDTH-1:0] wordOut;
    // lane picked by byteSel
    logic [7:0]             laneByte;
    // bit offset of the selected lane
    logic [4:0]             laneOffset;

    assign laneOffset = {byteSel, 3'b000};

    // stores land at the clock edge
    always_ff @(posedge clk) begin
        if (writeEn) begin
            case (op)
                opStoreWord: begin
                    mem[wordAddr] <= writeData;
                end
                opStoreByte: begin
                    // only the addressed lane changes
                    mem[wordAddr][laneOffset +: 8] <= writeData[7:0];
                end
                default: begin
                end
            endcase
        end
    end

    // combinational read so a store is seen by the next record
    assign wordOut  = mem[wordAddr];
    assign laneByte = wordOut[laneOffset +: 8];

    always_comb begin
        if (op == opLoadByte) begin
            // sign-extend the selected byte
            readData = {{(`DATA_WIDTH - 8){laneByte[7]}}, laneByte};
        end else begin
            // word loads and everything else
            readData = wordOut;
        end
    end

endmodule

// File: hw/memStage.sv
`timescale 1ns/1ps
`include "memPipe_consts.svh"

module memStage
    import memPipe_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       stall,
    input  logic                       clr,
    input  memOp                       opMem,
    input  logic [`DATA_WIDTH-1:0]     pcMem,
    input  logic [`DATA_WIDTH-1:0]     aluOutMem,
    input  logic [`DATA_WIDTH-1:0]     storeDataMem,
    input  logic [`REG_ADDR_WIDTH-1:0] rtAddrMem,
    input  logic [`REG_ADDR_WIDTH-1:0] regWriteAddrMem,
    input  logic [`DATA_WIDTH-1:0]     regWriteDataMem,
    input  logic [`REG_ADDR_WIDTH-1:0] fwdAddr,
    input  logic [`DATA_WIDTH-1:0]     fwdData,
    output memOp                       opWb,
    output logic [`DATA_WIDTH-1:0]     pcWb,
    output logic [`DATA_WIDTH-1:0]     memReadDataWb,
    output logic [`REG_ADDR_WIDTH-1:0] regWriteAddrWb,
    output logic [`DATA_WIDTH-1:0]     regWriteDataWb
);

    // store data after forwarding
    logic [`DATA_WIDTH-1:0]     storeData;
    logic [`DATA_WIDTH-1:0]     memReadData;
    logic [`DATA_WIDTH-1:0]     regWriteData;
    logic [`MEM_ADDR_WIDTH-1:0] wordAddr;
    logic [`BYTE_SEL_WIDTH-1:0] byteSel;
    logic                       isStore;
    logic                       isLoad;
    logic                       memWriteEn;

    // writeback result wins when it targets rt, never for r0
    assign storeData = (fwdAddr == rtAddrMem && fwdAddr != '0) ? fwdData : storeDataMem;

    assign isStore = (opMem == opStoreWord) || (opMem == opStoreByte);
    assign isLoad  = (opMem == opLoadWord) || (opMem == opLoadByte);

    // a stalled store would otherwise be written twice
    assign memWriteEn = isStore && !stall;

    // byte address split into word index and lane
    assign byteSel  = aluOutMem[`BYTE_SEL_WIDTH-1:0];
    assign wordAddr = aluOutMem[`MEM_ADDR_WIDTH+`BYTE_SEL_WIDTH-1:`BYTE_SEL_WIDTH];

    dataMemory u_dataMemory (
        .clk       (clk),
        .wordAddr  (wordAddr),
        .byteSel   (byteSel),
        .op        (opMem),
        .writeEn   (memWriteEn),
        .writeData (storeData),
        .readData  (memReadData)
    );

    // loads take memory data, others pass the ex result on
    assign regWriteData = isLoad ? memReadData : regWriteDataMem;

    // mem/wb register, clear beats stall
    always_ff @(posedge clk) begin
        if (!rstN || clr) begin
            opWb           <= opNone;
            pcWb           <= '0;
            memReadDataWb  <= '0;
            regWriteAddrWb <= '0;
            regWriteDataWb <= '0;
        end else if (!stall) begin
            opWb           <= opMem;
            pcWb           <= pcMem;
            memReadDataWb  <= memReadData;
            regWriteAddrWb <= regWriteAddrMem;
            regWriteDataWb <= regWriteData;
        end
    end

endmodule

// File: hw/writebackStage.sv
`timescale 1ns/1ps
`include "memPipe_consts.svh"

module writebackStage
    import memPipe_pkg::*;
(
    input  logic                       clk,
    input  memOp                       opWb,
    input  logic [`REG_ADDR_WIDTH-1:0] regWriteAddrWb,
    input  logic [`DATA_WIDTH-1:0]     regWriteDataWb,
    input  logic [`REG_ADDR_WIDTH-1:0] rsAddr,
    output logic [`DATA_WIDTH-1:0]     rsData,
    output logic [`REG_ADDR_WIDTH-1:0] fwdAddr,
    output logic [`DATA_WIDTH-1:0]     fwdData
);

    // one entry per register number
    logic [`DATA_WIDTH-1:0] regFile [1 << `REG_ADDR_WIDTH];

    // record targets a register
    logic writesReg;

    always_comb begin
        case (opWb)
            opAluWrite,
            opLoadWord,
            opLoadByte: writesReg = 1'b1;
            default:    writesReg = 1'b0;
        endcase
    end

    // r0 is never written
    always_ff @(posedge clk) begin
        if (writesReg && regWriteAddrWb != '0) begin
            regFile[regWriteAddrWb] <= regWriteDataWb;
        end
    end

    // decode-side read port, r0 reads as zero
    assign rsData = (rsAddr == '0) ? '0 : regFile[rsAddr];

    // forwarding pair back to the memory stage
    // address 0 means nothing is being written
    assign fwdAddr = writesReg ? regWriteAddrWb : '0;
    assign fwdData = regWriteDataWb;

endmodule

// File: hw/memPipeTop.sv
`timescale 1ns/1ps
`include "memPipe_consts.svh"

module memPipeTop
    import memPipe_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       stall,
    input  logic                       clr,
    input  memOp                       opMem,
    input  logic [`DATA_WIDTH-1:0]     pcMem,
    input  logic [`DATA_WIDTH-1:0]     aluOutMem,
    input  logic [`DATA_WIDTH-1:0]     storeDataMem,
    input  logic [`REG_ADDR_WIDTH-1:0] rtAddrMem,
    input  logic [`REG_ADDR_WIDTH-1:0] regWriteAddrMem,
    input  logic [`DATA_WIDTH-1:0]     regWriteDataMem,
    input  logic [`REG_ADDR_WIDTH-1:0] rsAddr,
    output logic [`DATA_WIDTH-1:0]     rsData,
    output memOp                       opWb,
    output logic [`DATA_WIDTH-1:0]     pcWb,
    output logic [`DATA_WIDTH-1:0]     memReadDataWb,
    output logic [`REG_ADDR_WIDTH-1:0] regWriteAddrWb,
    output logic [`DATA_WIDTH-1:0]     regWriteDataWb
);

    // forwarding pair from writeback
    logic [`REG_ADDR_WIDTH-1:0] fwdAddr;
    logic [`DATA_WIDTH-1:0]     fwdData;

    memStage u_memStage (
        .clk             (clk),
        .rstN            (rstN),
        .stall           (stall),
        .clr             (clr),
        .opMem           (opMem),
        .pcMem           (pcMem),
        .aluOutMem       (aluOutMem),
        .storeDataMem    (storeDataMem),
        .rtAddrMem       (rtAddrMem),
        .regWriteAddrMem (regWriteAddrMem),
        .regWriteDataMem (regWriteDataMem),
        .fwdAddr         (fwdAddr),
        .fwdData         (fwdData),
        .opWb            (opWb),
        .pcWb            (pcWb),
        .memReadDataWb   (memReadDataWb),
        .regWriteAddrWb  (regWriteAddrWb),
        .regWriteDataWb  (regWriteDataWb)
    );

    // consumes the mem/wb record one edge later
    writebackStage u_writebackStage (
        .clk            (clk),
        .opWb           (opWb),
        .regWriteAddrWb (regWriteAddrWb),
        .regWriteDataWb (regWriteDataWb),
        .rsAddr         (rsAddr),
        .rsData         (rsData),
        .fwdAddr        (fwdAddr),
        .fwdData        (fwdData)
    );

endmodule

// File: tb/memPipe_checker.sv
`timescale 1ns/1ps
`include "memPipe_consts.svh"

module memPipe_checker
    import memPipe_pkg::*;
(
    input logic                       clk,
    input logic                       rstN,
    input logic                       stall,
    input logic                       clr,
    input memOp                       opWb,
    input logic [`DATA_WIDTH-1:0]     pcWb,
    input logic [`DATA_WIDTH-1:0]     memReadDataWb,
    input logic [`REG_ADDR_WIDTH-1:0] regWriteAddrWb,
    input logic [`DATA_WIDTH-1:0]     regWriteDataWb
);

    // reset loads a bubble
    resetBubble: assert property (@(posedge clk) !rstN |=> opWb == opNone)
        else $error("opWb not opNone after reset");

    // clear wins over stall
    clearBubble: assert property (@(posedge clk) rstN && clr |=> opWb == opNone)
        else $error("opWb not opNone after clear");

    // stalled register holds every field
    stallHold: assert property (@(posedge clk) rstN && stall && !clr |=>
        $stable(opWb) && $stable(pcWb) && $stable(memReadDataWb) &&
        $stable(regWriteAddrWb) && $stable(regWriteDataWb))
        else $error("mem/wb register changed under stall");

endmodule

bind memStage memPipe_checker u_memPipeChecker (
    .clk            (clk),
    .rstN           (rstN),
    .stall          (stall),
    .clr            (clr),
    .opWb           (opWb),
    .pcWb           (pcWb),
    .memReadDataWb  (memReadDataWb),
    .regWriteAddrWb (regWriteAddrWb),
    .regWriteDataWb (regWriteDataWb)
);

// File: tb/memPipe_tb.sv
`timescale 1ns/1ps
`include "memPipe_consts.svh"

module memPipe_tb
    import memPipe_pkg::*;
();

    localparam string INPUT_FILE = "tb/memPipe_input.txt";
    localparam int MAX_LINES = 1000;
    localparam int MAX_CYCLES = 5000;
    localparam int OPEN_TRIES = 3;
    localparam int RANDOM_CYCLES = 40;
    localparam logic [31:0] SEED = 32'h0896_05d2;

    logic                       clk;
    logic                       rstN;
    logic                       stall;
    logic                       clr;
    memOp                       opMem;
    logic [`DATA_WIDTH-1:0]     pcMem;
    logic [`DATA_WIDTH-1:0]     aluOutMem;
    logic [`DATA_WIDTH-1:0]     storeDataMem;
    logic [`REG_ADDR_WIDTH-1:0] rtAddrMem;
    logic [`REG_ADDR_WIDTH-1:0] regWriteAddrMem;
    logic [`DATA_WIDTH-1:0]     regWriteDataMem;
    logic [`REG_ADDR_WIDTH-1:0] rsAddr;
    logic [`DATA_WIDTH-1:0]     rsData;
    memOp                       opWb;
    logic [`DATA_WIDTH-1:0]     pcWb;
    logic [`DATA_WIDTH-1:0]     memReadDataWb;
    logic [`REG_ADDR_WIDTH-1:0] regWriteAddrWb;
    logic [`DATA_WIDTH-1:0]     regWriteDataWb;

    // one stimulus record, as read from the file
    logic [2:0]  opV;
    logic        stallV;
    logic        clrV;
    logic [31:0] pcV;
    logic [31:0] addrV;
    logic [31:0] sdV;
    logic [4:0]  rtV;
    logic [4:0]  rdAddrV;
    logic [31:0] rdDataV;
    logic [4:0]  rsV;

    // reference model state
    logic [31:0] mMem [256];
    logic [31:0] mReg [32];
    logic        mRegOk [32];
    logic [2:0]  mOp;
    logic [31:0] mPc;
    logic [31:0] mRead;
    logic [4:0]  mAddr;
    logic [31:0] mData;

    logic [31:0] rngState;
    int          errorCount;
    int          cycleCount;

    memPipeTop u_memPipeTop (
        .clk             (clk),
        .rstN            (rstN),
        .stall           (stall),
        .clr             (clr),
        .opMem           (opMem),
        .pcMem           (pcMem),
        .aluOutMem       (aluOutMem),
        .storeDataMem    (storeDataMem),
        .rtAddrMem       (rtAddrMem),
        .regWriteAddrMem (regWriteAddrMem),
        .regWriteDataMem (regWriteDataMem),
        .rsAddr          (rsAddr),
        .rsData          (rsData),
        .opWb            (opWb),
        .pcWb            (pcWb),
        .memReadDataWb   (memReadDataWb),
        .regWriteAddrWb  (regWriteAddrWb),
        .regWriteDataWb  (regWriteDataWb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // stops the run if the clock keeps going too long
    initial begin
        cycleCount = 0;
        while (cycleCount < MAX_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: simulation ran for %0d cycles without finishing", MAX_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errorCount++;
            stopOnError("value mismatch");
        end
    endtask

    task automatic driveRecord();
        opMem           = memOp'(opV);
        stall           = stallV;
        clr             = clrV;
        pcMem           = pcV;
        aluOutMem       = addrV;
        storeDataMem    = sdV;
        rtAddrMem       = rtV;
        regWriteAddrMem = rdAddrV;
        regWriteDataMem = rdDataV;
        rsAddr          = rsV;
    endtask

    // what the pipeline does at one edge, from the stage rules
    task automatic modelEdge();
        logic        writes;
        logic [4:0]  fA;
        logic [31:0] sData;
        logic [7:0]  idx;
        logic [4:0]  laneBit;
        logic [31:0] word;
        logic [31:0] readV;
        logic [31:0] wData;
        writes  = (mOp == 3'd1) || (mOp == 3'd2) || (mOp == 3'd3);
        fA      = writes ? mAddr : 5'd0;
        sData   = (fA == rtV && fA != 5'd0) ? mData : sdV;
        idx     = addrV[9:2];
        laneBit = {addrV[1:0], 3'b000};
        word    = mMem[idx];
        if (opV == 3'd3) begin
            readV = {{24{word[laneBit + 5'd7]}}, word[laneBit +: 8]};
        end else begin
            readV = word;
        end
        wData = (opV == 3'd2 || opV == 3'd3) ? readV : rdDataV;
        // register write from the record already in writeback
        if (writes && mAddr != 5'd0) begin
            mReg[mAddr]   = mData;
            mRegOk[mAddr] = 1'b1;
        end
        if (!stallV && opV == 3'd4) begin
            mMem[idx] = sData;
        end
        if (!stallV && opV == 3'd5) begin
            mMem[idx][laneBit +: 8] = sData[7:0];
        end
        if (clrV) begin
            mOp   = 3'd0;
            mPc   = '0;
            mRead = '0;
            mAddr = '0;
            mData = '0;
        end else if (!stallV) begin
            mOp   = opV;
            mPc   = pcV;
            mRead = readV;
            mAddr = rdAddrV;
            mData = wData;
        end
    endtask

    task automatic checkAgainstModel();
        checkValue("opWb", {29'd0, opWb}, {29'd0, mOp});
        checkValue("pcWb", pcWb, mPc);
        checkValue("regWriteAddrWb", {27'd0, regWriteAddrWb}, {27'd0, mAddr});
        checkValue("regWriteDataWb", regWriteDataWb, mData);
        // loads only touch words the stimulus has written
        if (mOp == 3'd2 || mOp == 3'd3) begin
            checkValue("memReadDataWb", memReadDataWb, mRead);
        end
        // unwritten registers hold no known value
        if (rsV == 5'd0) begin
            checkValue("rsData r0", rsData, 32'd0);
        end else if (mRegOk[rsV]) begin
            checkValue("rsData", rsData, mReg[rsV]);
        end
    endtask

    task automatic runCycle();
        driveRecord();
        @(posedge clk);
        #1;
        modelEdge();
        checkAgainstModel();
    endtask

    initial begin
        int          fd;
        int          tries;
        int          lineCount;
        int          fields;
        string       line;
        logic [2:0]  eOp;
        logic [31:0] eData;
        logic [31:0] eRs;
        logic [31:0] r;
        errorCount = 0;
        rngState   = SEED;
        rstN       = 1'b0;
        opV        = 3'd0;
        stallV     = 1'b0;
        clrV       = 1'b0;
        pcV        = '0;
        addrV      = '0;
        sdV        = '0;
        rtV        = '0;
        rdAddrV    = '0;
        rdDataV    = '0;
        rsV        = '0;
        driveRecord();
        mOp   = 3'd0;
        mPc   = '0;
        mRead = '0;
        mAddr = '0;
        mData = '0;
        for (int i = 0; i < 32; i++) begin
            mRegOk[i] = 1'b0;
        end

        repeat (5) @(posedge clk);
        #1;
        checkValue("opWb after reset", {29'd0, opWb}, 32'd0);
        checkValue("pcWb after reset", pcWb, 32'd0);
        checkValue("memReadDataWb after reset", memReadDataWb, 32'd0);
        checkValue("regWriteAddrWb after reset", {27'd0, regWriteAddrWb}, 32'd0);
        checkValue("regWriteDataWb after reset", regWriteDataWb, 32'd0);
        rstN = 1'b1;

        fd    = 0;
        tries = 0;
        while (fd == 0 && tries < OPEN_TRIES) begin
            fd = $fopen(INPUT_FILE, "r");
            tries++;
        end
        if (fd == 0) begin
            stopOnError("could not open the stimulus file");
        end

        lineCount = 0;
        while ($fgets(line, fd) != 0) begin
            lineCount++;
            if (lineCount > MAX_LINES) begin
                stopOnError("stimulus file did not end within the line limit");
            end
            // comment and blank lines
            if (line.len() <= 1 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                             opV, stallV, clrV, pcV, addrV, sdV, rtV, rdAddrV,
                             rdDataV, rsV, eOp, eData, eRs);
            if (fields != 13) begin
                stopOnError("malformed line in the stimulus file");
            end
            runCycle();
            checkValue("opWb vs file", {29'd0, opWb}, {29'd0, eOp});
            checkValue("regWriteDataWb vs file", regWriteDataWb, eData);
            checkValue("rsData vs file", rsData, eRs);
        end
        $fclose(fd);

        // random alu writes and loads from words written above
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rngState = xorshift(rngState);
            r        = rngState;
            opV      = r[0] ? 3'd1 : (r[1] ? 3'd3 : 3'd2);
            case (r[10:8] % 3'd6)
                3'd0: addrV = 32'h10;
                3'd1: addrV = 32'h11;
                3'd2: addrV = 32'h12;
                3'd3: addrV = 32'h13;
                3'd4: addrV = 32'h20;
                default: addrV = 32'h24;
            endcase
            stallV   = 1'b0;
            clrV     = 1'b0;
            pcV      = 32'h200 + 32'(n * 4);
            sdV      = '0;
            rtV      = '0;
            rdAddrV  = r[15:11];
            rsV      = r[20:16];
            rngState = xorshift(rngState);
            rdDataV  = rngState;
            runCycle();
        end

        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "%0d checks failed", errorCount);
        end
    end

endmodule

// File: tb/memPipe_input.txt
# op stall clr pc addr storeData rt rd rdData rsAddr | expOpWb expWbData expRsData (hex)
# op: 0 none, 1 aluWrite, 2 loadWord, 3 loadByte, 4 storeWord, 5 storeByte
4 0 0 00000100 00000010 11223344 00 00 00000000 00 4 00000000 00000000
2 0 0 00000104 00000010 00000000 00 01 00000000 00 2 11223344 00000000
5 0 0 00000108 00000012 000000ab 00 00 00000000 01 5 00000000 11223344
2 0 0 0000010c 00000010 00000000 00 02 00000000 00 2 11ab3344 00000000
3 0 0 00000110 00000012 00000000 00 03 00000000 02 3 ffffffab 11ab3344
3 0 0 00000114 00000013 00000000 00 04 00000000 03 3 00000011 ffffffab
# forwarding from writeback into a store
1 0 0 00000118 00000000 00000000 00 05 cafef00d 04 1 cafef00d 00000011
4 0 0 0000011c 00000020 deaddead 05 00 00000000 05 4 00000000 cafef00d
2 0 0 00000120 00000020 00000000 00 06 00000000 00 2 cafef00d 00000000
# no forwarding through r0
1 0 0 00000124 00000000 00000000 00 00 12345678 06 1 12345678 cafef00d
4 0 0 00000128 00000024 0badbeef 00 00 00000000 00 4 00000000 00000000
2 0 0 0000012c 00000024 00000000 00 07 00000000 00 2 0badbeef 00000000
# stall holds and blocks stores
1 0 0 00000130 00000000 00000000 00 08 00000088 07 1 00000088 0badbeef
4 1 0 00000134 00000020 55555555 00 00 00000000 08 1 00000088 00000088
4 1 0 00000138 00000020 66666666 00 00 00000000 00 1 00000088 00000000
2 0 0 0000013c 00000020 00000000 00 09 00000000 00 2 cafef00d 00000000
# clear, also with stall high
1 1 1 00000140 00000000 00000000 00 0a 0a0a0a0a 09 0 00000000 cafef00d
1 0 1 00000144 00000000 00000000 00 0b 0b0b0b0b 00 0 00000000 00000000
1 0 0 00000148 00000000 00000000 00 0c 0c0c0c0c 00 1 0c0c0c0c 00000000
0 0 0 0000014c 00000000 00000000 00 00 00000000 0c 0 00000000 0c0c0c0c

// File: sources.f
+incdir+hw
hw/memPipe_pkg.sv
hw/dataMemory.sv
hw/memStage.sv
hw/writebackStage.sv
hw/memPipeTop.sv
tb/memPipe_checker.sv
tb/memPipe_tb.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
TOP        := memPipe_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
BIN        := $(BUILD_DIR)/V$(TOP)
LOG        := sim.log
PASS_MSG   := ALL CHECKS PASSED
SRCS       := $(wildcard hw/*.sv hw/*.svh tb/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN) tb/memPipe_input.txt
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
